//--- Makefile
SIM      = verilator
VFLAGS   = --binary --timing
TOP      = tb_awe_rowbuffers
FILELIST = list.f
MDIR     = obj_dir
PASS     = No errors

BIN  = $(MDIR)/V$(TOP)
SRCS = $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(MDIR)

//--- dv/tb_awe_rowbuffers.sv
`include "awe_cfg.svh"

module tb_awe_rowbuffers;
    import awe_pkg::*;

    localparam int read_delay  = `AWE_RD_LATENCY + 1;
    localparam int drain_limit = 16;

    typedef enum logic [2:0] {op_idle, op_prime, op_read, op_row, op_drain} op_e;

    // One stimulus step and the pair it should return
    typedef struct packed {
        op_e         op;
        awe_state_e  state;
        logic [1:0]  gray;
        col_t        row;
        col_t        col;
        col_t        num_cols;
        logic        last_kernel;
        pixel_t      pixel;
        seq_word_u   seq;
        logic        expect_rd;
        pixel_pair_t expected;
    } entry_t;

    typedef struct packed {
        pixel_pair_t pair;
        int          issued;
    } pending_t;

    logic        clk;
    logic        rst;
    awe_state_e  state;
    logic [1:0]  gray_code;
    col_t        input_row;
    col_t        input_col;
    col_t        num_input_cols;
    logic        pfb_rden;
    pixel_t      pixel_in;
    col_t        wr_addr;
    logic        row_strobe;
    logic        last_kernel;
    logic        execute;
    seq_word_u   seq_word;
    pixel_pair_t pixel_out;
    logic        pixel_out_valid;

    // Reference copy of both banks
    pixel_t   model_even [`AWE_RAM_DEPTH];
    pixel_t   model_odd [`AWE_RAM_DEPTH];
    entry_t   stim [$];
    pending_t pending [$];
    integer   seed;
    int       cycle;
    int       pair_errors;
    int       valid_errors;
    logic     timed_out;

    awe_rowbuffers dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_pair(input pixel_pair_t expected, input pixel_pair_t actual);
        if (actual !== expected) begin
            pair_errors++;
            $display("[ERROR] %0t pixel_out expected %h got %h", $time, expected, actual);
        end
    endtask

    task automatic check_valid(input logic expected, input logic actual);
        if (actual !== expected) begin
            valid_errors++;
            $display("[ERROR] %0t pixel_out_valid expected %b got %b", $time, expected, actual);
        end
    endtask

    // Advance to the next falling edge, retire the oldest read once valid shows
    task automatic next_cycle();
        logic due;
        @(negedge clk);
        cycle++;
        due = (pending.size() != 0) && (pending[0].issued + read_delay == cycle);
        check_valid(due, pixel_out_valid);
        if (pixel_out_valid === 1'b1 && pending.size() != 0) begin
            check_pair(pending[0].pair, pixel_out);
            pending.delete(0);
        end
    endtask

    task automatic release_controls();
        execute    = 1'b0;
        pfb_rden   = 1'b0;
        row_strobe = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Table construction
    ////////////////////////////////////////////////////////////

    function automatic pixel_t random_pixel();
        logic [31:0] r;
        r = $random(seed);
        return r[`AWE_PIXEL_W-1:0];
    endfunction

    task automatic idle_cycles(input awe_state_e st, input int n);
        entry_t e;
        e       = '0;
        e.op    = op_idle;
        e.state = st;
        repeat (n) stim.push_back(e);
    endtask

    task automatic prime_pixel(input col_t row, input col_t col, input col_t ncols);
        entry_t e;
        e          = '0;
        e.op       = op_prime;
        e.state    = st_prim_buffer;
        e.row      = row;
        e.col      = col;
        e.num_cols = ncols;
        e.pixel    = random_pixel();
        if (col <= ncols) begin
            if (row == 0) begin
                model_even[{1'b0, col}] = e.pixel;
                model_odd[{1'b0, col}]  = e.pixel;
            end else if (row == 1) begin
                model_odd[{1'b1, col}] = e.pixel;
            end else if (row == 2) begin
                model_even[{1'b1, col}] = e.pixel;
            end
        end
        stim.push_back(e);
    endtask

    task automatic read_pair(input awe_state_e st, input logic [1:0] gray, input logic rf,
                             input logic [7:0] oc, input logic par, input logic low);
        entry_t      e;
        logic [15:0] raw;
        logic [9:0]  even_a;
        logic [9:0]  odd_a;
        logic [31:0] r;
        r   = $random(seed);
        raw = {rf, 1'b0, oc, r[3:0], par, low};
        // Even column sits in [14:6], odd column in [13:6] plus merged low bit
        even_a = {gray[0] ^ raw[15], raw[14:6]};
        odd_a  = {gray[1] ^ raw[15], raw[13:6], raw[1] | raw[0]};
        e           = '0;
        e.op        = op_read;
        e.state     = st;
        e.gray      = gray;
        e.seq       = raw;
        e.expect_rd = (st == st_active);
        e.expected  = '{odd: model_odd[odd_a], even: model_even[even_a]};
        stim.push_back(e);
    endtask

    task automatic drain_reads();
        entry_t e;
        e    = '0;
        e.op = op_drain;
        stim.push_back(e);
    endtask

    // New row write, then a read of the location it targets
    task automatic incoming_row(input logic [1:0] gray, input col_t addr, input logic lk);
        entry_t e;
        e             = '0;
        e.op          = op_row;
        e.state       = st_active;
        e.gray        = gray;
        e.col         = addr;
        e.last_kernel = lk;
        e.pixel       = random_pixel();
        if (lk && gray[0] == gray[1]) begin
            model_odd[{gray[0], addr}] = e.pixel;
        end else if (lk) begin
            model_even[{gray[0], addr}] = e.pixel;
        end
        stim.push_back(e);
        if (gray[0] == gray[1]) begin
            read_pair(st_active, gray, 1'b0, addr[8:1], 1'b0, addr[0]);
        end else begin
            read_pair(st_active, gray, 1'b0, addr[7:0], 1'b0, 1'b0);
        end
        drain_reads();
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [1:0]  gc;
        idle_cycles(st_idle, 6);
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 16; c++) begin
                prime_pixel(col_t'(r), col_t'(c), col_t'(15));
            end
        end
        // Short row 0 pass, columns past the limit keep the first pass
        for (int c = 0; c < 6; c++) begin
            prime_pixel(col_t'(0), col_t'(c), col_t'(2));
        end
        idle_cycles(st_wait_pfb_load, 2);
        for (int g = 0; g < 4; g++) begin
            for (int v = 0; v < 4; v++) begin
                rnd = $random(seed);
                read_pair(st_active, g[1:0], rnd[4], {5'b0, rnd[2:0]}, v[1], v[0]);
                drain_reads();
            end
        end
        // Back-to-back burst
        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            read_pair(st_active, rnd[9:8], rnd[4], {5'b0, rnd[2:0]}, rnd[6], rnd[5]);
        end
        drain_reads();
        for (int g = 0; g < 4; g++) begin
            gc  = g[1:0] ^ {1'b0, g[1]};
            rnd = $random(seed);
            incoming_row(gc, {6'b0, rnd[2:0]}, 1'b1);
            incoming_row(gc, {6'b0, rnd[6:4]}, 1'b0);
        end
        // Execute outside the active state
        read_pair(st_idle, 2'b00, 1'b0, 8'd1, 1'b0, 1'b0);
        read_pair(st_prim_buffer, 2'b01, 1'b0, 8'd2, 1'b0, 1'b1);
        read_pair(st_job_done, 2'b11, 1'b1, 8'd3, 1'b1, 1'b0);
        idle_cycles(st_idle, 4);
        drain_reads();
    endtask

    ////////////////////////////////////////////////////////////
    // Table replay
    ////////////////////////////////////////////////////////////

    task automatic apply_entry(input entry_t e);
        int       waited;
        pending_t req;
        next_cycle();
        release_controls();
        // Draining keeps the layer state of the step before
        if (e.op != op_drain) begin
            state = e.state;
        end
        case (e.op)
            op_prime: begin
                pfb_rden       = 1'b1;
                input_row      = e.row;
                input_col      = e.col;
                num_input_cols = e.num_cols;
                pixel_in       = e.pixel;
            end
            op_read: begin
                gray_code = e.gray;
                seq_word  = e.seq;
                execute   = 1'b1;
                if (e.expect_rd) begin
                    req.pair   = e.expected;
                    req.issued = cycle;
                    pending.push_back(req);
                end
            end
            op_row: begin
                // Pixel and address stay put around the single strobe
                gray_code   = e.gray;
                wr_addr     = e.col;
                pixel_in    = e.pixel;
                last_kernel = e.last_kernel;
                repeat (2) next_cycle();
                row_strobe = 1'b1;
                next_cycle();
                row_strobe = 1'b0;
                repeat (2) next_cycle();
            end
            op_drain: begin
                waited = 0;
                while (pending.size() != 0 && waited < drain_limit) begin
                    next_cycle();
                    waited++;
                end
                if (pending.size() != 0) begin
                    timed_out = 1'b1;
                    $display("Timeout: %0d reads got no pixel_out_valid within %0d cycles",
                             pending.size(), drain_limit);
                end
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        rst            = 1'b1;
        state          = st_idle;
        gray_code      = 2'b00;
        input_row      = '0;
        input_col      = '0;
        num_input_cols = '0;
        pfb_rden       = 1'b0;
        pixel_in       = '0;
        wr_addr        = '0;
        row_strobe     = 1'b0;
        last_kernel    = 1'b0;
        execute        = 1'b0;
        seq_word       = '0;
        seed           = 17;
        cycle          = 0;
        pair_errors    = 0;
        valid_errors   = 0;
        timed_out      = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < stim.size() && !timed_out; i++) begin
            apply_entry(stim[i]);
        end
        $display("Checks done: %0d pixel_out mismatches, %0d pixel_out_valid mismatches",
                 pair_errors, valid_errors);
        if (timed_out || pair_errors + valid_errors != 0) begin
            $display("Errors found");
        end else begin
            $display("No errors");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+src
src/awe_pkg.sv
src/awe_row_ram.sv
src/awe_read_port.sv
src/awe_write_ctrl.sv
src/awe_rowbuffers.sv
dv/tb_awe_rowbuffers.sv

//--- src/awe_cfg.svh
`ifndef AWE_CFG_SVH
`define AWE_CFG_SVH

// Pixel word and bank geometry
`define AWE_PIXEL_W 16
`define AWE_RAM_DEPTH 1024
`define AWE_ADDR_W 10

// Column index within one half-row
// Top bank address bit selects the half
`define AWE_COL_W (`AWE_ADDR_W - 1)

// Sequencer word from the kernel sequencer
`define AWE_SEQ_W 16

// Pipeline delays in clock cycles
`define AWE_RD_LATENCY 2
`define AWE_PIXEL_DELAY 2
`define AWE_ROW_STROBE_DELAY 1

`endif

//--- src/awe_pkg.sv
`include "awe_cfg.svh"

package awe_pkg;

    ////////////////////////////////////////////////////////////
    // Layer state
    ////////////////////////////////////////////////////////////

    // One-hot, driven by the layer controller
    typedef enum logic [4:0] {
        st_idle          = 5'b00001,
        st_prim_buffer   = 5'b00010,
        st_wait_pfb_load = 5'b00100,
        st_active        = 5'b01000,
        st_job_done      = 5'b10000
    } awe_state_e;

    ////////////////////////////////////////////////////////////
    // Pixel and RAM port types
    ////////////////////////////////////////////////////////////

    typedef logic [`AWE_PIXEL_W-1:0] pixel_t;
    typedef logic [`AWE_COL_W-1:0] col_t;

    // Half-row select on top of the column
    typedef struct packed {
        logic half;
        col_t col;
    } ram_addr_t;

    typedef struct packed {
        logic      en;
        ram_addr_t addr;
        pixel_t    data;
    } ram_wr_t;

    typedef struct packed {
        logic      en;
        ram_addr_t addr;
    } ram_rd_t;

    // Odd bank in the upper half
    typedef struct packed {
        pixel_t odd;
        pixel_t even;
    } pixel_pair_t;

    ////////////////////////////////////////////////////////////
    // Sequencer word
    ////////////////////////////////////////////////////////////

    // Even bank reads a full column index
    typedef struct packed {
        logic                               row_flag;
        col_t                               even_col;
        logic [`AWE_SEQ_W-`AWE_COL_W-2:0]   rsvd;
    } seq_even_t;

    // Odd bank reads a narrower column plus parity and low bit
    typedef struct packed {
        logic                               row_flag;
        logic                               rsvd_hi;
        logic [`AWE_COL_W-2:0]              odd_col;
        logic [`AWE_SEQ_W-`AWE_COL_W-4:0]   rsvd_lo;
        logic                               parity;
        logic                               low;
    } seq_odd_t;

    // Same word, decoded once per bank
    typedef union packed {
        seq_even_t even;
        seq_odd_t  odd;
    } seq_word_u;

endpackage

//--- src/awe_read_port.sv
`include "awe_cfg.svh"

module awe_read_port (
    input  logic                   clk,
    input  logic                   rst,
    input  awe_pkg::awe_state_e    state,
    input  logic [1:0]             gray_code,
    input  logic                   execute,
    input  awe_pkg::seq_word_u     seq_word,
    output awe_pkg::ram_rd_t       rd_even,
    output awe_pkg::ram_rd_t       rd_odd,
    output logic                   rdata_valid
);
    import awe_pkg::*;

    ram_addr_t                  even_addr;
    ram_addr_t                  odd_addr;
    ram_addr_t                  even_addr_q;
    ram_addr_t                  odd_addr_q;
    logic                       rd_go;
    logic                       rd_en;
    logic [`AWE_RD_LATENCY-1:0] valid_sr;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    // Row flag toggles the half picked by the gray phase
    assign even_addr.half = gray_code[0] ^ seq_word.even.row_flag;
    assign even_addr.col  = seq_word.even.even_col;

    // Odd column widened by the merged low bit
    assign odd_addr.half = gray_code[1] ^ seq_word.odd.row_flag;
    assign odd_addr.col  = {seq_word.odd.odd_col, seq_word.odd.low | seq_word.odd.parity};

    assign rd_go = execute && (state == st_active);

    ////////////////////////////////////////////////////////////
    // Request registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en <= 1'b0;
        end else begin
            rd_en <= rd_go;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            even_addr_q <= even_addr;
            odd_addr_q  <= odd_addr;
        end
    end

    // Both banks read together
    assign rd_even = '{en: rd_en, addr: even_addr_q};
    assign rd_odd  = '{en: rd_en, addr: odd_addr_q};

    // Valid tracks the RAM read pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= rd_en;
            for (int i = 1; i < `AWE_RD_LATENCY; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    assign rdata_valid = valid_sr[`AWE_RD_LATENCY-1];

endmodule

//--- src/awe_row_ram.sv
`include "awe_cfg.svh"

module awe_row_ram (
    input  logic             clk,
    input  awe_pkg::ram_wr_t wr,
    input  awe_pkg::ram_rd_t rd,
    output awe_pkg::pixel_t  rdata
);
    import awe_pkg::*;

    pixel_t mem [`AWE_RAM_DEPTH];
    pixel_t mem_q;
    logic   rd_en_q;

    // Write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Two-stage read
    ////////////////////////////////////////////////////////////

    // Array read into the memory register
    always_ff @(posedge clk) begin
        rd_en_q <= rd.en;
        if (rd.en) begin
            mem_q <= mem[rd.addr];
        end
    end

    // Output register follows one cycle later
    always_ff @(posedge clk) begin
        if (rd_en_q) begin
            rdata <= mem_q;
        end
    end

endmodule

//--- src/awe_rowbuffers.sv
module awe_rowbuffers (
    input  logic                 clk,
    input  logic                 rst,
    input  awe_pkg::awe_state_e  state,
    input  logic [1:0]           gray_code,
    input  awe_pkg::col_t        input_row,
    input  awe_pkg::col_t        input_col,
    input  awe_pkg::col_t        num_input_cols,
    input  logic                 pfb_rden,
    input  awe_pkg::pixel_t      pixel_in,
    input  awe_pkg::col_t        wr_addr,
    input  logic                 row_strobe,
    input  logic                 last_kernel,
    input  logic                 execute,
    input  awe_pkg::seq_word_u   seq_word,
    output awe_pkg::pixel_pair_t pixel_out,
    output logic                 pixel_out_valid
);
    import awe_pkg::*;

    ram_wr_t wr_even;
    ram_wr_t wr_odd;
    ram_rd_t rd_even;
    ram_rd_t rd_odd;
    pixel_t  rdata_even;
    pixel_t  rdata_odd;

    ////////////////////////////////////////////////////////////
    // Read and write control
    ////////////////////////////////////////////////////////////

    awe_read_port u_read_port (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .gray_code   (gray_code),
        .execute     (execute),
        .seq_word    (seq_word),
        .rd_even     (rd_even),
        .rd_odd      (rd_odd),
        .rdata_valid (pixel_out_valid)
    );

    awe_write_ctrl u_write_ctrl (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .gray_code      (gray_code),
        .input_row      (input_row),
        .input_col      (input_col),
        .num_input_cols (num_input_cols),
        .pfb_rden       (pfb_rden),
        .pixel_in       (pixel_in),
        .wr_addr        (wr_addr),
        .row_strobe     (row_strobe),
        .last_kernel    (last_kernel),
        .wr_even        (wr_even),
        .wr_odd         (wr_odd)
    );

    ////////////////////////////////////////////////////////////
    // Pixel banks
    ////////////////////////////////////////////////////////////

    awe_row_ram bank_even (
        .clk   (clk),
        .wr    (wr_even),
        .rd    (rd_even),
        .rdata (rdata_even)
    );

    awe_row_ram bank_odd (
        .clk   (clk),
        .wr    (wr_odd),
        .rd    (rd_odd),
        .rdata (rdata_odd)
    );

    assign pixel_out = '{odd: rdata_odd, even: rdata_even};

endmodule

//--- src/awe_write_ctrl.sv
`include "awe_cfg.svh"

module awe_write_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  awe_pkg::awe_state_e state,
    input  logic [1:0]          gray_code,
    input  awe_pkg::col_t       input_row,
    input  awe_pkg::col_t       input_col,
    input  awe_pkg::col_t       num_input_cols,
    input  logic                pfb_rden,
    input  awe_pkg::pixel_t     pixel_in,
    input  awe_pkg::col_t       wr_addr,
    input  logic                row_strobe,
    input  logic                last_kernel,
    output awe_pkg::ram_wr_t    wr_even,
    output awe_pkg::ram_wr_t    wr_odd
);
    import awe_pkg::*;

    pixel_t                           pixel_d [`AWE_PIXEL_DELAY];
    logic [`AWE_ROW_STROBE_DELAY-1:0] strobe_d;
    logic                             prime_ok;
    logic                             row_wr;
    ram_wr_t                          even_n;
    ram_wr_t                          odd_n;
    logic                             even_en;
    logic                             odd_en;
    ram_addr_t                        even_addr;
    ram_addr_t                        odd_addr;
    pixel_t                           even_data;
    pixel_t                           odd_data;

    ////////////////////////////////////////////////////////////
    // Delay lines
    ////////////////////////////////////////////////////////////

    // Covers the prefetch buffer latency
    always_ff @(posedge clk) begin
        pixel_d[0] <= pixel_in;
        for (int i = 1; i < `AWE_PIXEL_DELAY; i++) begin
            pixel_d[i] <= pixel_d[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            strobe_d <= '0;
        end else begin
            strobe_d[0] <= row_strobe;
            for (int i = 1; i < `AWE_ROW_STROBE_DELAY; i++) begin
                strobe_d[i] <= strobe_d[i-1];
            end
        end
    end

    assign prime_ok = pfb_rden && (input_col <= num_input_cols);
    assign row_wr   = strobe_d[`AWE_ROW_STROBE_DELAY-1] && last_kernel;

    ////////////////////////////////////////////////////////////
    // Write select
    ////////////////////////////////////////////////////////////

    always_comb begin
        even_n = '0;
        odd_n  = '0;
        case (state)
            st_prim_buffer: begin
                // First row lands in both banks
                if (prime_ok && input_row == 0) begin
                    even_n = '{en: 1'b1, addr: '{half: 1'b0, col: input_col}, data: pixel_in};
                    odd_n  = '{en: 1'b1, addr: '{half: 1'b0, col: input_col}, data: pixel_in};
                end else if (prime_ok && input_row == 1) begin
                    odd_n  = '{en: 1'b1, addr: '{half: 1'b1, col: input_col}, data: pixel_in};
                end else if (prime_ok && input_row == 2) begin
                    even_n = '{en: 1'b1, addr: '{half: 1'b1, col: input_col}, data: pixel_in};
                end
            end
            st_active: begin
                // Equal gray bits mean the odd bank takes the new row
                if (row_wr && (gray_code[0] == gray_code[1])) begin
                    odd_n = '{en: 1'b1, addr: '{half: gray_code[0], col: wr_addr},
                              data: pixel_d[`AWE_PIXEL_DELAY-1]};
                end else if (row_wr) begin
                    even_n = '{en: 1'b1, addr: '{half: gray_code[0], col: wr_addr},
                               data: pixel_d[`AWE_PIXEL_DELAY-1]};
                end
            end
            default: begin
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Write registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            even_en <= 1'b0;
            odd_en  <= 1'b0;
        end else begin
            even_en <= even_n.en;
            odd_en  <= odd_n.en;
        end
    end

    always_ff @(posedge clk) begin
        even_addr <= even_n.addr;
        even_data <= even_n.data;
        odd_addr  <= odd_n.addr;
        odd_data  <= odd_n.data;
    end

    assign wr_even = '{en: even_en, addr: even_addr, data: even_data};
    assign wr_odd  = '{en: odd_en, addr: odd_addr, data: odd_data};

endmodule
